//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// bus and data widths
`define ADDR_W     32
`define DATA_W     64
`define STRB_W     8

// cache geometry, one doubleword per line
`define OFFS_BITS  3
`define SET_BITS   4
`define SETS       16
`define TAG_W      (`ADDR_W - `SET_BITS - `OFFS_BITS)

// the LRU is a single bit per set, so two ways only
`define WAYS       2

// AXI response codes
`define AXI_OKAY   2'b00

`endif

//--- cachePkg.sv
`default_nettype none

`include "cache_defines.svh"

package cachePkg;

    typedef enum logic [3:0] {
        opLb, opLh, opLw, opLd, opLbu, opLhu, opLwu,
        opSb, opSh, opSw, opSd
    } memOp_e;

    typedef enum logic [2:0] {
        stIdle, stLookup, stRefill, stWrite, stRespond
    } ctrlState_e;

    typedef struct packed {
        memOp_e              op;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  wdata;
    } cpuReq_t;

    typedef struct packed {
        logic [`DATA_W-1:0]  data;
        logic                err;
    } cpuRsp_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]    addr;
        logic [`TAG_W-1:0]     tag;
        logic [`SET_BITS-1:0]  set;
        logic [`OFFS_BITS-1:0] offs;
        memOp_e                op;
        logic                  isLoad;
        logic [`DATA_W-1:0]    wdata;  // already in its byte lane
        logic [`STRB_W-1:0]    strb;
    } reqInfo_t;

    typedef struct packed {
        logic                write;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  data;
        logic [`STRB_W-1:0]  strb;
    } memCmd_t;

    typedef struct packed {
        logic [`DATA_W-1:0]  data;
        logic                err;
    } memRes_t;

    typedef struct packed {
        logic                awvalid;
        logic [`ADDR_W-1:0]  awaddr;
        logic                wvalid;
        logic [`DATA_W-1:0]  wdata;
        logic [`STRB_W-1:0]  wstrb;
        logic                bready;
        logic                arvalid;
        logic [`ADDR_W-1:0]  araddr;
        logic                rready;
    } axiReq_t;

    typedef struct packed {
        logic                awready;
        logic                wready;
        logic                bvalid;
        logic [1:0]          bresp;
        logic                arready;
        logic                rvalid;
        logic [`DATA_W-1:0]  rdata;
        logic [1:0]          rresp;
    } axiRsp_t;

endpackage

`default_nettype wire

//--- reqStage.sv
`default_nettype none

`include "cache_defines.svh"

module reqStage (
    input  logic               clk,
    input  logic               arstN,
    input  logic               reqValid,
    output logic               reqReady,
    input  cachePkg::cpuReq_t  req,
    input  logic               releaseSlot,
    output logic               heldValid,
    output cachePkg::reqInfo_t info
);
    import cachePkg::*;

    reqInfo_t           nextInfo;
    logic [`STRB_W-1:0] sizeMask;
    logic               accept;

    assign reqReady = !heldValid;
    assign accept   = reqValid && reqReady;

    always_comb begin
        case (req.op)
            opSb:    sizeMask = `STRB_W'h01;
            opSh:    sizeMask = `STRB_W'h03;
            opSw:    sizeMask = `STRB_W'h0f;
            opSd:    sizeMask = `STRB_W'hff;
            default: sizeMask = '0;  // loads write nothing
        endcase
    end

    always_comb begin
        nextInfo.addr   = req.addr;
        nextInfo.tag    = req.addr[`ADDR_W-1 -: `TAG_W];
        nextInfo.set    = req.addr[`OFFS_BITS +: `SET_BITS];
        nextInfo.offs   = req.addr[`OFFS_BITS-1:0];
        nextInfo.op     = req.op;
        nextInfo.isLoad = !(req.op inside {opSb, opSh, opSw, opSd});
        nextInfo.strb   = sizeMask << nextInfo.offs;
        nextInfo.wdata  = req.wdata << {nextInfo.offs, 3'b000};  // move into byte lane
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
        end else if (accept) begin
            heldValid <= 1'b1;
        end else if (releaseSlot) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            info <= nextInfo;
        end
    end

endmodule

`default_nettype wire

//--- cacheStore.sv
`default_nettype none

`include "cache_defines.svh"

module cacheStore (
    input  logic               clk,
    input  logic               arstN,
    input  cachePkg::reqInfo_t info,
    input  logic               touch,
    input  logic               merge,
    input  logic               fill,
    input  logic [`DATA_W-1:0] fillData,
    output logic               hit,
    output logic [`DATA_W-1:0] hitData
);
    import cachePkg::*;

    logic [`TAG_W-1:0]              tagArr  [`WAYS][`SETS];
    logic [`DATA_W-1:0]             dataArr [`WAYS][`SETS];
    logic [`SETS-1:0][`WAYS-1:0]    validArr;
    logic [`SETS-1:0]               lruArr;  // way to replace next

    logic [`WAYS-1:0] wayHit;
    logic             hitWay;
    logic             victim;

    always_comb begin
        for (int w = 0; w < `WAYS; w++) begin
            wayHit[w] = validArr[info.set][w] && (tagArr[w][info.set] == info.tag);
        end
    end

    assign hit     = |wayHit;
    assign hitWay  = wayHit[1];
    assign hitData = dataArr[hitWay][info.set];
    assign victim  = lruArr[info.set];

    // valid and LRU state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validArr <= '0;
            lruArr   <= '0;
        end else if (fill) begin
            validArr[info.set][victim] <= 1'b1;
            lruArr[info.set]           <= !victim;
        end else if (touch || merge) begin
            lruArr[info.set] <= !hitWay;  // other way becomes LRU
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill) begin
            tagArr[victim][info.set]  <= info.tag;
            dataArr[victim][info.set] <= fillData;
        end else if (merge) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (info.strb[b]) begin
                    dataArr[hitWay][info.set][8*b +: 8] <= info.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- cacheCtrl.sv
`default_nettype none

`include "cache_defines.svh"

module cacheCtrl (
    input  logic               clk,
    input  logic               arstN,
    input  logic               heldValid,
    input  cachePkg::reqInfo_t info,
    output logic               releaseSlot,
    input  logic               hit,
    input  logic [`DATA_W-1:0] hitData,
    output logic               touch,
    output logic               merge,
    output logic               fill,
    output logic [`DATA_W-1:0] fillData,
    output logic               cmdValid,
    output cachePkg::memCmd_t  cmd,
    input  logic               done,
    input  cachePkg::memRes_t  res,
    output logic               rspValid,
    input  logic               rspReady,
    output logic [`DATA_W-1:0] rawData,
    output logic               rspErr
);
    import cachePkg::*;

    ctrlState_e         state;
    ctrlState_e         nextState;
    logic [`DATA_W-1:0] rawQ;
    logic               errQ;

    always_comb begin
        nextState   = state;
        touch       = 1'b0;
        merge       = 1'b0;
        fill        = 1'b0;
        cmdValid    = 1'b0;
        releaseSlot = 1'b0;
        case (state)
            stIdle: begin
                if (heldValid) nextState = stLookup;
            end
            stLookup: begin
                if (info.isLoad && hit) begin
                    touch     = 1'b1;
                    nextState = stRespond;
                end else if (info.isLoad) begin
                    cmdValid  = 1'b1;  // line read
                    nextState = stRefill;
                end else begin
                    merge     = hit;  // write-through, no allocate on miss
                    cmdValid  = 1'b1;
                    nextState = stWrite;
                end
            end
            stRefill: begin
                if (done) begin
                    fill      = !res.err;  // bad data never enters the cache
                    nextState = stRespond;
                end
            end
            stWrite: begin
                if (done) nextState = stRespond;
            end
            stRespond: begin
                if (rspReady) begin
                    releaseSlot = 1'b1;
                    nextState   = stIdle;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (state == stLookup && info.isLoad && hit) begin
            rawQ <= hitData;
            errQ <= 1'b0;
        end else if (state == stRefill && done) begin
            rawQ <= res.data;
            errQ <= res.err;
        end else if (state == stWrite && done) begin
            rawQ <= '0;
            errQ <= res.err;
        end
    end

    always_comb begin
        cmd.write = !info.isLoad;
        cmd.addr  = {info.addr[`ADDR_W-1:`OFFS_BITS], {`OFFS_BITS{1'b0}}};  // doubleword aligned
        cmd.data  = info.wdata;
        cmd.strb  = info.strb;
    end

    assign fillData = res.data;
    assign rspValid = (state == stRespond);
    assign rawData  = rawQ;
    assign rspErr   = errQ;

endmodule

`default_nettype wire

//--- loadAlign.sv
`default_nettype none

`include "cache_defines.svh"

module loadAlign (
    input  logic [`DATA_W-1:0] rawData,
    input  cachePkg::reqInfo_t info,
    output logic [`DATA_W-1:0] loadData
);
    import cachePkg::*;

    logic [`DATA_W-1:0] shifted;
    logic [7:0]         byteVal;
    logic [15:0]        halfVal;
    logic [31:0]        wordVal;

    assign shifted = rawData >> {info.offs, 3'b000};  // lane down to bit 0
    assign byteVal = shifted[7:0];
    assign halfVal = shifted[15:0];
    assign wordVal = shifted[31:0];

    always_comb begin
        case (info.op)
            opLb:    loadData = {{56{byteVal[7]}}, byteVal};
            opLh:    loadData = {{48{halfVal[15]}}, halfVal};
            opLw:    loadData = {{32{wordVal[31]}}, wordVal};
            opLd:    loadData = rawData;
            opLbu:   loadData = {56'b0, byteVal};
            opLhu:   loadData = {48'b0, halfVal};
            opLwu:   loadData = {32'b0, wordVal};
            default: loadData = '0;  // stores
        endcase
    end

endmodule

`default_nettype wire

//--- axiLiteMaster.sv
`default_nettype none

`include "cache_defines.svh"

module axiLiteMaster (
    input  logic              clk,
    input  logic              arstN,
    input  logic              cmdValid,
    input  cachePkg::memCmd_t cmd,
    output logic              done,
    output cachePkg::memRes_t res,
    output cachePkg::axiReq_t axiOut,
    input  cachePkg::axiRsp_t axiIn
);
    import cachePkg::*;

    logic               awPend;
    logic               wPend;
    logic               arPend;
    logic               bWait;
    logic               rWait;
    logic               idle;
    logic [`ADDR_W-1:0] addrQ;
    logic [`DATA_W-1:0] dataQ;
    logic [`STRB_W-1:0] strbQ;

    assign idle = !(awPend || wPend || arPend || bWait || rWait);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            awPend <= 1'b0;
            wPend  <= 1'b0;
            arPend <= 1'b0;
            bWait  <= 1'b0;
            rWait  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmdValid && idle) begin
                awPend <= cmd.write;
                wPend  <= cmd.write;
                bWait  <= cmd.write;
                arPend <= !cmd.write;
                rWait  <= !cmd.write;
            end
            if (axiOut.awvalid && axiIn.awready) awPend <= 1'b0;
            if (axiOut.wvalid && axiIn.wready) wPend <= 1'b0;
            if (axiOut.arvalid && axiIn.arready) arPend <= 1'b0;
            if (axiOut.bready && axiIn.bvalid) begin
                bWait <= 1'b0;
                done  <= 1'b1;
            end
            if (axiOut.rready && axiIn.rvalid) begin
                rWait <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid && idle) begin
            addrQ <= cmd.addr;
            dataQ <= cmd.data;
            strbQ <= cmd.strb;
        end
        if (axiOut.bready && axiIn.bvalid) res.err <= (axiIn.bresp != `AXI_OKAY);
        if (axiOut.rready && axiIn.rvalid) begin
            res.data <= axiIn.rdata;
            res.err  <= (axiIn.rresp != `AXI_OKAY);
        end
    end

    always_comb begin
        axiOut.awvalid = awPend;
        axiOut.awaddr  = addrQ;
        axiOut.wvalid  = wPend;
        axiOut.wdata   = dataQ;
        axiOut.wstrb   = strbQ;
        axiOut.bready  = bWait && !awPend && !wPend;  // both halves accepted
        axiOut.arvalid = arPend;
        axiOut.araddr  = addrQ;
        axiOut.rready  = rWait && !arPend;
    end

endmodule

`default_nettype wire

//--- dataCache.sv
`default_nettype none

`include "cache_defines.svh"

module dataCache (
    input  logic              clk,
    input  logic              arstN,
    input  logic              reqValid,
    output logic              reqReady,
    input  cachePkg::cpuReq_t req,
    output logic              rspValid,
    input  logic              rspReady,
    output cachePkg::cpuRsp_t rsp,
    output cachePkg::axiReq_t axiOut,
    input  cachePkg::axiRsp_t axiIn
);
    import cachePkg::*;

    reqInfo_t           info;
    memCmd_t            cmd;
    memRes_t            res;
    logic               heldValid;
    logic               releaseSlot;
    logic               hit;
    logic               touch;
    logic               merge;
    logic               fill;
    logic               cmdValid;
    logic               done;
    logic               rspErr;
    logic [`DATA_W-1:0] hitData;
    logic [`DATA_W-1:0] fillData;
    logic [`DATA_W-1:0] rawData;
    logic [`DATA_W-1:0] loadData;

    reqStage reqStage_i (
        .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .releaseSlot(releaseSlot), .heldValid(heldValid), .info(info)
    );

    cacheStore cacheStore_i (
        .clk(clk), .arstN(arstN), .info(info), .touch(touch), .merge(merge), .fill(fill),
        .fillData(fillData), .hit(hit), .hitData(hitData)
    );

    cacheCtrl cacheCtrl_i (
        .clk(clk), .arstN(arstN), .heldValid(heldValid), .info(info),
        .releaseSlot(releaseSlot), .hit(hit), .hitData(hitData), .touch(touch),
        .merge(merge), .fill(fill), .fillData(fillData), .cmdValid(cmdValid), .cmd(cmd),
        .done(done), .res(res), .rspValid(rspValid), .rspReady(rspReady),
        .rawData(rawData), .rspErr(rspErr)
    );

    loadAlign loadAlign_i (.rawData(rawData), .info(info), .loadData(loadData));

    axiLiteMaster axiLiteMaster_i (
        .clk(clk), .arstN(arstN), .cmdValid(cmdValid), .cmd(cmd), .done(done), .res(res),
        .axiOut(axiOut), .axiIn(axiIn)
    );

    assign rsp.data = loadData;
    assign rsp.err  = rspErr;

endmodule

`default_nettype wire

//--- tbAxiMem.sv
`default_nettype none

`include "cache_defines.svh"

module tbAxiMem (
    input  logic              clk,
    input  logic              arstN,
    input  cachePkg::axiReq_t busReq,
    output cachePkg::axiRsp_t busRsp,
    output int unsigned       arCount
);
    timeunit 1ns;
    timeprecision 1ps;
    import cachePkg::*;

    localparam logic [31:0] SEED   = 32'hcdbf_8af4;
    localparam logic [31:0] ERR_LO = 32'h0000_f000;  // SLVERR window
    localparam logic [31:0] ERR_HI = 32'h0000_f0ff;

    logic [`DATA_W-1:0] written [8192];  // indexed by addr[15:3]
    logic [8191:0]      isWritten;
    logic               tick;
    logic               awGot;
    logic               wGot;
    logic               bvalidQ;
    logic               rvalidQ;
    logic [1:0]         brespQ;
    logic [1:0]         rrespQ;
    logic [`ADDR_W-1:0] awAddrQ;
    logic [`DATA_W-1:0] wDataQ;
    logic [`DATA_W-1:0] rdataQ;
    logic [`STRB_W-1:0] wStrbQ;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [`DATA_W-1:0] readWord(input logic [`ADDR_W-1:0] addr);
        logic [31:0] hi;
        if (isWritten[addr[15:3]]) return written[addr[15:3]];
        hi = xorshift((addr >> 3) ^ SEED);  // pattern over the whole doubleword address
        return {hi, xorshift(hi)};
    endfunction

    function automatic logic [`DATA_W-1:0] mergeBytes(input logic [`DATA_W-1:0] old,
                                                      input logic [`DATA_W-1:0] data,
                                                      input logic [`STRB_W-1:0] strb);
        logic [`DATA_W-1:0] word;
        word = old;
        for (int b = 0; b < `STRB_W; b++) begin
            if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    function automatic logic inWindow(input logic [`ADDR_W-1:0] addr);
        return (addr >= ERR_LO) && (addr <= ERR_HI);
    endfunction

    always_comb begin
        busRsp.awready = !awGot && tick;  // AW and W taken on alternate cycles
        busRsp.wready  = !wGot && !tick;
        busRsp.bvalid  = bvalidQ;
        busRsp.bresp   = brespQ;
        busRsp.arready = !rvalidQ && tick;
        busRsp.rvalid  = rvalidQ;
        busRsp.rdata   = rdataQ;
        busRsp.rresp   = rrespQ;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tick      <= 1'b0;
            awGot     <= 1'b0;
            wGot      <= 1'b0;
            bvalidQ   <= 1'b0;
            rvalidQ   <= 1'b0;
            isWritten <= '0;
            arCount   <= 0;
        end else begin
            tick <= !tick;
            if (busReq.awvalid && busRsp.awready) awGot <= 1'b1;
            if (busReq.wvalid && busRsp.wready) wGot <= 1'b1;
            if (awGot && wGot && !bvalidQ) begin
                bvalidQ <= 1'b1;
                awGot   <= 1'b0;
                wGot    <= 1'b0;
                if (!inWindow(awAddrQ)) isWritten[awAddrQ[15:3]] <= 1'b1;
            end
            if (bvalidQ && busReq.bready) bvalidQ <= 1'b0;
            if (busReq.arvalid && busRsp.arready) begin
                rvalidQ <= 1'b1;
                arCount <= arCount + 1;
            end
            if (rvalidQ && busReq.rready) rvalidQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (busReq.awvalid && busRsp.awready) awAddrQ <= busReq.awaddr;
        if (busReq.wvalid && busRsp.wready) begin
            wDataQ <= busReq.wdata;
            wStrbQ <= busReq.wstrb;
        end
        if (awGot && wGot && !bvalidQ) begin
            brespQ <= inWindow(awAddrQ) ? 2'b10 : 2'b00;
            if (!inWindow(awAddrQ)) begin
                written[awAddrQ[15:3]] <= mergeBytes(readWord(awAddrQ), wDataQ, wStrbQ);
            end
        end
        if (busReq.arvalid && busRsp.arready) begin
            rrespQ <= inWindow(busReq.araddr) ? 2'b10 : 2'b00;
            rdataQ <= inWindow(busReq.araddr) ? '0 : readWord(busReq.araddr);
        end
    end

endmodule

`default_nettype wire

//--- tbDataCache.sv
`default_nettype none

`include "cache_defines.svh"

module tbDataCache;
    timeunit 1ns;
    timeprecision 1ps;
    import cachePkg::*;

    localparam logic [31:0] SEED       = 32'hcdbf_8af4;
    localparam int          ROW_CYCLES = 40;

    typedef struct packed {
        memOp_e             op;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [`DATA_W-1:0] expData;
        logic               expErr;
        logic               expAr;  // one bus read expected
    } stimRow_t;

    logic        clk = 1'b0;
    logic        arstN;
    logic        reqValid;
    logic        reqReady;
    cpuReq_t     req;
    logic        rspValid;
    logic        rspReady;
    cpuRsp_t     rsp;
    axiReq_t     axiReq;
    axiRsp_t     axiRsp;
    int unsigned arCount;

    stimRow_t           rows[$];
    logic [`DATA_W-1:0] shadow [int unsigned];  // memory after all stores so far
    logic [31:0]        rngState = SEED;
    logic               tableBuilt = 1'b0;

    dataCache dataCache_i (
        .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .rspValid(rspValid), .rspReady(rspReady), .rsp(rsp), .axiOut(axiReq), .axiIn(axiRsp)
    );

    tbAxiMem axiMem_i (
        .clk(clk), .arstN(arstN), .busReq(axiReq), .busRsp(axiRsp), .arCount(arCount)
    );

    always #50 clk = !clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [`DATA_W-1:0] memWord(input logic [`ADDR_W-1:0] addr);
        logic [31:0] hi;
        if (shadow.exists(addr >> 3)) return shadow[addr >> 3];
        hi = xorshift((addr >> 3) ^ SEED);
        return {hi, xorshift(hi)};
    endfunction

    function automatic int storeBytes(input memOp_e op);
        case (op)
            opSb:    return 1;
            opSh:    return 2;
            opSw:    return 4;
            opSd:    return 8;
            default: return 0;
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] applyStore(input logic [`DATA_W-1:0] old,
                                                      input logic [`DATA_W-1:0] data,
                                                      input logic [2:0] offs, input int bytes);
        logic [`DATA_W-1:0] result;
        result = old;
        for (int b = 0; b < bytes; b++) begin
            result[8*(int'(offs)+b) +: 8] = data[8*b +: 8];
        end
        return result;
    endfunction

    function automatic logic [`DATA_W-1:0] expectLoad(input memOp_e op,
                                                      input logic [`DATA_W-1:0] word,
                                                      input logic [2:0] offs);
        logic [`DATA_W-1:0] lane;
        lane = word >> (8 * offs);
        case (op)
            opLb:    return 64'($signed(lane[7:0]));
            opLh:    return 64'($signed(lane[15:0]));
            opLw:    return 64'($signed(lane[31:0]));
            opLbu:   return 64'(lane[7:0]);
            opLhu:   return 64'(lane[15:0]);
            opLwu:   return 64'(lane[31:0]);
            default: return word;
        endcase
    endfunction

    function automatic void addRow(input memOp_e op, input logic [`ADDR_W-1:0] addr,
                                   input logic expAr, input logic expErr);
        stimRow_t           r;
        logic [`DATA_W-1:0] word;
        word      = memWord(addr);
        r.op      = op;
        r.addr    = addr;
        r.wdata   = {nextRandom(), nextRandom()};
        r.expErr  = expErr;
        r.expAr   = expAr;
        r.expData = '0;  // stores and bus errors answer zero
        if (storeBytes(op) > 0) begin
            shadow[addr >> 3] = applyStore(word, r.wdata, addr[2:0], storeBytes(op));
        end else if (!expErr) begin
            r.expData = expectLoad(op, word, addr[2:0]);
        end
        rows.push_back(r);
    endfunction

    function automatic void buildTable();
        // one cold miss per load size
        addRow(opLb, 32'h0000_0105, 1'b1, 1'b0);
        addRow(opLh, 32'h0000_020a, 1'b1, 1'b0);
        addRow(opLw, 32'h0000_0314, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_0418, 1'b1, 1'b0);
        addRow(opLbu, 32'h0000_0523, 1'b1, 1'b0);
        addRow(opLhu, 32'h0000_062e, 1'b1, 1'b0);
        addRow(opLwu, 32'h0000_0734, 1'b1, 1'b0);
        // hits on filled lines
        addRow(opLbu, 32'h0000_0104, 1'b0, 1'b0);
        addRow(opLh, 32'h0000_020c, 1'b0, 1'b0);
        addRow(opLd, 32'h0000_0418, 1'b0, 1'b0);
        addRow(opLwu, 32'h0000_0730, 1'b0, 1'b0);
        addRow(opLb, 32'h0000_0527, 1'b0, 1'b0);
        // store hits read back from the cache
        addRow(opSw, 32'h0000_0418, 1'b0, 1'b0);
        addRow(opSb, 32'h0000_041b, 1'b0, 1'b0);
        addRow(opSh, 32'h0000_041e, 1'b0, 1'b0);
        addRow(opSd, 32'h0000_0310, 1'b0, 1'b0);
        addRow(opLd, 32'h0000_0418, 1'b0, 1'b0);
        addRow(opLw, 32'h0000_0314, 1'b0, 1'b0);
        addRow(opLd, 32'h0000_0310, 1'b0, 1'b0);
        // evict 0x418 from set 3 and reload the strobed bytes from memory
        addRow(opLd, 32'h0000_0498, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_0518, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_0418, 1'b1, 1'b0);
        // evict the doubleword store at 0x310 from set 2
        addRow(opLd, 32'h0000_0390, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_0410, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_0310, 1'b1, 1'b0);
        // store miss leaves the cache alone
        addRow(opSw, 32'h0000_0804, 1'b0, 1'b0);
        addRow(opLwu, 32'h0000_0804, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_0800, 1'b0, 1'b0);
        // LRU in set 8 with tags A, B, C
        addRow(opLd, 32'h0000_1040, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_1140, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_1040, 1'b0, 1'b0);
        addRow(opLd, 32'h0000_1240, 1'b1, 1'b0);
        addRow(opLd, 32'h0000_1040, 1'b0, 1'b0);
        addRow(opLd, 32'h0000_1140, 1'b1, 1'b0);
        // error window never fills
        addRow(opLd, 32'h0000_f010, 1'b1, 1'b1);
        addRow(opLd, 32'h0000_f010, 1'b1, 1'b1);
        addRow(opLw, 32'h0000_f014, 1'b1, 1'b1);
        addRow(opLbu, 32'h0000_0105, 1'b0, 1'b0);
    endfunction

    task automatic stopOnFailure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic checkRspData(input string name, input cpuRsp_t got, input cpuRsp_t exp);
        if (got.data !== exp.data) begin
            stopOnFailure($sformatf("ERROR t=%0t %s got %h expected %h",
                                    $time, name, got.data, exp.data));
        end
    endtask

    task automatic checkRspErr(input string name, input cpuRsp_t got, input cpuRsp_t exp);
        if (got.err !== exp.err) begin
            stopOnFailure($sformatf("ERROR t=%0t %s got %b expected %b",
                                    $time, name, got.err, exp.err));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopOnFailure($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkArCount(input string name, input int unsigned got,
                                input int unsigned exp);
        if (got !== exp) begin
            stopOnFailure($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic runRow(input stimRow_t r, input int idx);
        int unsigned arBefore;
        int unsigned stall;
        cpuRsp_t     exp;
        exp.data = r.expData;
        exp.err  = r.expErr;
        while (!reqReady) begin
            @(posedge clk);
            #5;
        end
        arBefore  = arCount;
        req.op    = r.op;
        req.addr  = r.addr;
        req.wdata = r.wdata;
        reqValid  = 1'b1;
        @(posedge clk);  // accepted here
        #5;
        reqValid = 1'b0;
        while (!rspValid) begin
            @(posedge clk);
            #5;
        end
        stall = nextRandom() % 4;  // hold the response back a little
        repeat (stall) begin
            @(posedge clk);
            #5;
        end
        checkBit($sformatf("rspValid row %0d", idx), rspValid, 1'b1);
        checkBit($sformatf("reqReady row %0d", idx), reqReady, 1'b0);
        checkRspData($sformatf("rsp.data row %0d", idx), rsp, exp);
        checkRspErr($sformatf("rsp.err row %0d", idx), rsp, exp);
        checkArCount($sformatf("AR count row %0d", idx), arCount - arBefore, 32'(r.expAr));
        rspReady = 1'b1;
        @(posedge clk);
        #5;
        rspReady = 1'b0;
    endtask

    initial begin
        arstN    = 1'b0;
        reqValid = 1'b0;
        rspReady = 1'b0;
        req      = '0;
        buildTable();
        tableBuilt = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        arstN = 1'b1;
        checkBit("reqReady", reqReady, 1'b1);
        checkBit("rspValid", rspValid, 1'b0);
        checkBit("awvalid", axiReq.awvalid, 1'b0);
        checkBit("wvalid", axiReq.wvalid, 1'b0);
        checkBit("arvalid", axiReq.arvalid, 1'b0);
        checkBit("bready", axiReq.bready, 1'b0);
        checkBit("rready", axiReq.rready, 1'b0);
        foreach (rows[i]) runRow(rows[i], i);
        $display("TESTS PASSED");
        $finish;
    end

    // reset time counted as two rows
    initial begin
        int unsigned limit;
        wait (tableBuilt);
        limit = (rows.size() + 2) * ROW_CYCLES;
        repeat (limit) @(posedge clk);
        stopOnFailure($sformatf("watchdog timeout, the run did not finish in %0d cycles", limit));
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
cachePkg.sv
reqStage.sv
cacheStore.sv
cacheCtrl.sv
loadAlign.sv
axiLiteMaster.sv
dataCache.sv
tbAxiMem.sv
tbDataCache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tbDataCache -o simDataCache

# the pipe keeps the log even when the run stops early
./obj_dir/simDataCache 2>&1 | tee sim.log

grep -q "^TESTS PASSED$" sim.log
echo "simulation finished cleanly"
